// ==== tb.f ====
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
sim/uart_checker.sv
sim/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
   -f tb.f --top-module uart_tb -o uart_sim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

out=$(./obj_dir/uart_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
   echo "run passed"
   exit 0
fi

echo "run failed"
exit 1

// ==== sim/uart_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tb;

   import uart_pkg::*;

   typedef struct packed {
      cmd_t       cmd;
      logic       inj;                           // 1 drives rx directly, 0 loops tx back.
      logic [1:0] bad;                           // 1 flips frame two parity, 2 drops its stop.
      logic [1:0] gap;                           // idle cycles before cmd_vld.
   } entry_t;

   localparam int WAIT_CYCLES = CMD_BITS * CLKS_PER_BIT + 40;

   logic        clk;
   logic        rst_n;
   cmd_t        cmd_in;
   logic        cmd_vld;
   wire         cmd_rdy;
   wire         tx;
   wire         rx_line;
   logic        rx_drv;
   logic        lb_sel;
   wire byte_t  read_data;
   wire         read_rdy;
   wire         frame_err;
   logic        entry_bad;
   logic        done;
   logic        tbl_ready;
   logic [31:0] n_cmds;
   int          rst_errs;
   int          hs_errs;
   int          tx_errs;
   int          rx_errs;
   int          total;
   int          n_strobes = 0;
   entry_t      tbl [$];

   assign rx_line = lb_sel ? tx : rx_drv;

   uart_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .rx        (rx_line),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .frame_err (frame_err)
   );

   uart_checker u_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .frame_err (frame_err),
      .bad_lo    (entry_bad),
      .done      (done),
      .n_cmds    (n_cmds),
      .rst_errs  (rst_errs),
      .hs_errs   (hs_errs),
      .tx_errs   (tx_errs),
      .rx_errs   (rx_errs)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (read_rdy)
         n_strobes++;                            // end marker for the run.
   end

   task automatic next_cycle;
      @(posedge clk);
      #2;
   endtask

   task automatic add_entry(input cmd_t c, input logic inj, input logic [1:0] bad,
                            input logic [1:0] gap);
      tbl.push_back(entry_t'({c, inj, bad, gap}));
   endtask

   task automatic drive_bit(input logic v);
      rx_drv = v;
      repeat (CLKS_PER_BIT) next_cycle();
   endtask

   // drives both frames onto rx in step with the same command on tx.
   task automatic send_frames(input cmd_t c, input logic [1:0] bad);
      byte_t b;
      logic  par;
      logic  stop;
      rx_drv = 1'b0;
      lb_sel = 1'b0;
      for (int f = 0; f < 2; f++)
      begin
         b    = (f == 0) ? c[15:8] : c[7:0];
         par  = ~^b;
         stop = 1'b1;
         if (f == 1 && bad == 2'd1)
            par = ~par;
         if (f == 1 && bad == 2'd2)
            stop = 1'b0;
         drive_bit(1'b0);
         for (int k = 0; k < 8; k++)
         begin
            drive_bit(b[7]);
            b = b << 1;
         end
         drive_bit(par);
         drive_bit(stop);
      end
      rx_drv = 1'b1;
      lb_sel = 1'b1;
   endtask

   task automatic apply_entry(input entry_t e);
      if (e.gap != 2'd0)
      begin
         cmd_vld = 1'b0;
         repeat (e.gap) next_cycle();
      end
      cmd_in    = e.cmd;
      entry_bad = (e.bad != 2'd0);
      cmd_vld   = 1'b1;
      while (!cmd_rdy)
         next_cycle();                           // held off until the line is free.
      next_cycle();
      cmd_vld = 1'b0;
      if (e.inj)
         send_frames(e.cmd, e.bad);
   endtask

   initial
   begin
      logic       r_inj;
      logic [1:0] r_bad;
      rst_n     = 1'b0;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      rx_drv    = 1'b1;
      lb_sel    = 1'b1;
      entry_bad = 1'b0;
      done      = 1'b0;
      tbl_ready = 1'b0;
      void'($urandom(32'h87d1_bf06));

      add_entry(16'hA55A, 1'b0, 2'd0, 2'd0);
      add_entry(16'h0000, 1'b0, 2'd0, 2'd0);
      add_entry(16'hFFFF, 1'b0, 2'd0, 2'd3);
      add_entry(16'h1234, 1'b1, 2'd0, 2'd0);
      add_entry(16'h8001, 1'b1, 2'd1, 2'd0);
      add_entry(16'h7E81, 1'b0, 2'd0, 2'd0);
      add_entry(16'hC3F0, 1'b1, 2'd2, 2'd1);
      add_entry(16'h0F0F, 1'b1, 2'd0, 2'd0);
      add_entry(16'h00FF, 1'b0, 2'd0, 2'd2);
      for (int i = 0; i < 8; i++)
      begin
         r_inj = 1'($urandom % 2);
         r_bad = r_inj ? 2'($urandom % 3) : 2'd0;
         add_entry(cmd_t'($urandom), r_inj, r_bad, 2'($urandom % 4));
      end
      n_cmds    = 32'(tbl.size());
      tbl_ready = 1'b1;

      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      repeat (10) next_cycle();                  // idle stretch after reset.

      foreach (tbl[i])
         apply_entry(tbl[i]);
      while (n_strobes < 2 * tbl.size())
         next_cycle();
      repeat (20) next_cycle();
      done = 1'b1;
      repeat (2) next_cycle();

      total = rst_errs + hs_errs + tx_errs + rx_errs;
      $display("errors: reset %0d, handshake %0d, tx %0d, rx %0d, total %0d",
               rst_errs, hs_errs, tx_errs, rx_errs, total);
      if (total == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      int limit;
      wait (tbl_ready);
      limit = int'(n_cmds) * WAIT_CYCLES + 300;
      repeat (limit) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/uart_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_checker (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire uart_pkg::cmd_t  cmd_in,
   input  wire                  cmd_vld,
   input  wire                  cmd_rdy,
   input  wire                  tx,
   input  wire uart_pkg::byte_t read_data,
   input  wire                  read_rdy,
   input  wire                  frame_err,
   input  wire                  bad_lo,        // low byte of this command arrives damaged.
   input  wire                  done,
   input  wire [31:0]           n_cmds,
   output int                   rst_errs,
   output int                   hs_errs,
   output int                   tx_errs,
   output int                   rx_errs
);

   import uart_pkg::*;

   localparam int BUSY_CYCLES = CMD_BITS * CLKS_PER_BIT;

   int                  n_rst      = 0;
   int                  n_hs       = 0;
   int                  n_tx       = 0;
   int                  n_rx       = 0;
   int                  n_acc      = 0;
   int                  n_sent     = 0;
   int                  n_rcv      = 0;
   int                  rdy_timer  = 0;
   int                  tx_cyc     = 0;
   int                  tx_left    = 0;
   logic                started    = 1'b0;
   logic                tx_active  = 1'b0;
   logic                rdy_prev   = 1'b0;
   logic                final_done = 1'b0;
   logic [CMD_BITS-1:0] tx_exp;
   logic [8:0]          rx_exp [$];          // {frame_err, byte} per strobe.
   logic [8:0]          rx_head;

   assign rst_errs = n_rst;
   assign hs_errs  = n_hs;
   assign tx_errs  = n_tx;
   assign rx_errs  = n_rx;

   function automatic logic odd_parity(input byte_t b);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++)
         ones += int'(b[i]);
      return (ones % 2 == 0);                 // parity bit tops an even count up to odd.
   endfunction

   // start, data msb first, parity, stop; high byte leads.
   function automatic logic [CMD_BITS-1:0] line_bits(input cmd_t c);
      byte_t hi;
      byte_t lo;
      hi = c[15:8];
      lo = c[7:0];
      return {1'b0, hi, odd_parity(hi), 1'b1, 1'b0, lo, odd_parity(lo), 1'b1};
   endfunction

   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if (!started &&
             (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0 || frame_err !== 1'b0))
         begin
            $display("Fail reset: tx = %h, cmd_rdy = %h, read_rdy = %h, frame_err = %h",
                     tx, cmd_rdy, read_rdy, frame_err);
            n_rst++;
         end

         if (started)
         begin
            if (cmd_rdy !== (rdy_timer == 0))
            begin
               $display("Fail cmd_rdy: cmd_rdy = %h, expected %h", cmd_rdy, rdy_timer == 0);
               n_hs++;
            end
            if (rdy_timer > 0)
               rdy_timer--;
         end

         if (tx_active)
         begin
            tx_cyc++;
            if (tx_cyc % CLKS_PER_BIT == HALF_BIT)   // middle of the bit.
            begin
               if (tx !== tx_exp[CMD_BITS-1])
               begin
                  $display("Fail tx: bit %0d tx = %h, expected %h",
                           CMD_BITS - tx_left, tx, tx_exp[CMD_BITS-1]);
                  n_tx++;
               end
               tx_exp = tx_exp << 1;
               tx_left--;
               if (tx_left == 0)
               begin
                  tx_active = 1'b0;
                  n_sent++;
               end
            end
         end

         if (cmd_vld && cmd_rdy)
         begin
            started   = 1'b1;
            n_acc++;
            rdy_timer = BUSY_CYCLES;
            tx_exp    = line_bits(cmd_in);
            tx_cyc    = 0;
            tx_left   = CMD_BITS;
            tx_active = 1'b1;
            rx_exp.push_back({1'b0, cmd_in[15:8]});
            rx_exp.push_back({bad_lo, cmd_in[7:0]});
         end

         if (read_rdy)
         begin
            n_rcv++;
            if (rdy_prev)
            begin
               $display("read_rdy stayed high for more than one cycle");
               n_rx++;
            end
            if (rx_exp.size() == 0)
            begin
               $display("read_rdy strobe arrived with no byte outstanding");
               n_rx++;
            end
            else
            begin
               rx_head = rx_exp.pop_front();
               if (read_data !== rx_head[7:0])
               begin
                  $display("Fail read_data: read_data = %h, expected %h", read_data, rx_head[7:0]);
                  n_rx++;
               end
               if (frame_err !== rx_head[8])
               begin
                  $display("Fail frame_err: frame_err = %h, expected %h", frame_err, rx_head[8]);
                  n_rx++;
               end
            end
         end
         rdy_prev = read_rdy;

         if (done && !final_done)
         begin
            final_done = 1'b1;
            if (n_acc != int'(n_cmds) || n_sent != n_acc)
            begin
               $display("%0d commands accepted and %0d sent, %0d expected",
                        n_acc, n_sent, n_cmds);
               n_hs++;
            end
            if (n_rcv != 2 * int'(n_cmds) || rx_exp.size() != 0)
            begin
               $display("%0d bytes received, %0d expected", n_rcv, 2 * n_cmds);
               n_rx++;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/uart_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_top (
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire uart_pkg::cmd_t  cmd_in,
   input  wire                  cmd_vld,
   output wire                  cmd_rdy,
   output wire                  tx,
   input  wire                  rx,
   output wire uart_pkg::byte_t read_data,
   output wire                  read_rdy,
   output wire                  frame_err
);

   // command side sends two frames per accepted word.
   uart_tx u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   // receive side runs on its own and strobes each byte out.
   uart_rx u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .frame_err (frame_err)
   );

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
   input  wire              clk,
   input  wire              rst_n,
   input  wire              rx,
   output uart_pkg::byte_t  read_data,
   output logic             read_rdy,
   output logic             frame_err
);

   import uart_pkg::*;

   logic      rx_meta;
   logic      rx_sync;
   logic      rx_prev;
   logic      rx_fall;
   rx_state_t state;
   baud_cnt_t baud_cnt;
   logic [2:0] data_cnt;
   byte_t     data_sr;
   logic      parity_bit;
   logic      half_end;
   logic      bit_end;
   logic      stop_sample;

   // two-flop synchronizer plus one flop for edge detection.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign rx_fall     = rx_prev & ~rx_sync;
   assign half_end    = (baud_cnt == baud_cnt_t'(HALF_BIT - 1));
   assign bit_end     = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
   assign stop_sample = (state == RX_STOP) && bit_end;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= RX_IDLE;
         baud_cnt <= '0;
         data_cnt <= '0;
      end
      else
      begin
         case (state)
            RX_IDLE:
            begin
               baud_cnt <= '0;
               data_cnt <= '0;
               if (rx_fall)
               begin
                  state <= RX_START;
               end
            end
            RX_START:
            begin
               if (half_end)
               begin
                  baud_cnt <= '0;
                  state    <= rx_sync ? RX_IDLE : RX_DATA;   // high again means glitch.
               end
               else
               begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_DATA:
            begin
               if (bit_end)
               begin
                  baud_cnt <= '0;
                  data_cnt <= data_cnt + 1'b1;
                  if (data_cnt == 3'd7)
                  begin
                     state <= RX_PARITY;
                  end
               end
               else
               begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_PARITY:
            begin
               if (bit_end)
               begin
                  baud_cnt <= '0;
                  state    <= RX_STOP;
               end
               else
               begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_STOP:
            begin
               if (bit_end)
               begin
                  baud_cnt <= '0;
                  state    <= RX_IDLE;               // back in time for the next edge.
               end
               else
               begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default:
            begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((state == RX_DATA) && bit_end)
      begin
         data_sr <= {data_sr[6:0], rx_sync};         // msb arrives first.
      end
      if ((state == RX_PARITY) && bit_end)
      begin
         parity_bit <= rx_sync;
      end
      if (stop_sample)
      begin
         read_data <= data_sr;
      end
   end

   // even ones over data and parity, or a low stop, flags the byte.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         read_rdy  <= 1'b0;
         frame_err <= 1'b0;
      end
      else
      begin
         read_rdy  <= stop_sample;
         frame_err <= stop_sample & ((~^{data_sr, parity_bit}) | ~rx_sync);
      end
   end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire uart_pkg::cmd_t cmd_in,
   input  wire                 cmd_vld,
   output logic                cmd_rdy,
   output logic                tx
);

   import uart_pkg::*;

   byte_t               hi_byte;
   byte_t               lo_byte;
   logic                par_hi;
   logic                par_lo;
   logic [CMD_BITS-1:0] frame;
   logic [CMD_BITS-2:0] shift_reg;
   baud_cnt_t           baud_cnt;
   bit_cnt_t            bit_cnt;
   logic                accept;
   logic                bit_end;
   logic                last_bit;

   assign hi_byte = cmd_in[15:8];
   assign lo_byte = cmd_in[7:0];

   assign par_hi = ~^hi_byte;                        // odd parity.
   assign par_lo = ~^lo_byte;

   // high byte leaves first and each byte goes msb first.
   assign frame = {1'b0, hi_byte, par_hi, 1'b1,
                   1'b0, lo_byte, par_lo, 1'b1};

   assign accept   = cmd_vld & cmd_rdy;
   assign bit_end  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
   assign last_bit = (bit_cnt == bit_cnt_t'(CMD_BITS - 1));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_rdy <= 1'b1;
      end
      else if (accept)
      begin
         cmd_rdy <= 1'b0;
      end
      else if (!cmd_rdy && bit_end && last_bit)
      begin
         cmd_rdy <= 1'b1;                            // stop bit of low frame done.
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         baud_cnt <= '0;
      end
      else if (cmd_rdy || bit_end)
      begin
         baud_cnt <= '0;
      end
      else
      begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         bit_cnt <= '0;
      end
      else if (cmd_rdy)
      begin
         bit_cnt <= '0;
      end
      else if (bit_end)
      begin
         bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         shift_reg <= frame[CMD_BITS-2:0];
      end
      else if (!cmd_rdy && bit_end)
      begin
         shift_reg <= {shift_reg[CMD_BITS-3:0], 1'b1};   // ones fill behind.
      end
   end

   // tx takes the start bit right at acceptance, so it lines up with cmd_rdy.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tx <= 1'b1;
      end
      else if (accept)
      begin
         tx <= frame[CMD_BITS-1];
      end
      else if (!cmd_rdy && bit_end)
      begin
         tx <= shift_reg[CMD_BITS-2];               // idles high after the last bit.
      end
   end

endmodule

`default_nettype wire

// ==== source/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

   localparam int CLKS_PER_BIT = 8;                  // short bit time keeps sims quick.
   localparam int HALF_BIT     = CLKS_PER_BIT / 2;   // start edge to start sample.
   localparam int FRAME_BITS   = 11;                 // start, 8 data, parity, stop.
   localparam int CMD_BITS     = 2 * FRAME_BITS;     // high frame then low frame.

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] cmd_t;
   typedef logic [4:0]  bit_cnt_t;                   // reaches CMD_BITS.

   // one spare state so the count can reach CLKS_PER_BIT itself.
   typedef logic [$clog2(CLKS_PER_BIT + 1) - 1:0] baud_cnt_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_PARITY,
      RX_STOP
   } rx_state_t;

endpackage

`default_nettype wire
